/* logic/pipeline_pkg.sv */
`default_nettype none

package pipeline_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 16;

  typedef logic [$clog2(reg_count)-1:0] reg_addr_t;
  typedef logic [xlen-1:0] data_t;

  typedef enum logic [3:0] {
    nop    = 4'd0,
    add    = 4'd1,
    sub    = 4'd2,
    and_op = 4'd3,
    or_op  = 4'd4,
    xor_op = 4'd5,
    addi   = 4'd6,
    load   = 4'd7,
    store  = 4'd8
  } opcode_t;

  typedef struct packed {
    opcode_t   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
  } instr_t;

  // after execute, rdata1 carries the alu result or the memory address
  typedef struct packed {
    logic   valid;
    instr_t instr;
    data_t  rdata1;
    data_t  rdata2;
  } slot_t;

  localparam slot_t init_slot = '{
    valid: 1'b0,
    instr: '{op: nop, rd: '0, rs1: '0, rs2: '0, imm: '0},
    rdata1: '0,
    rdata2: '0
  };

  function automatic logic uses_rs1(input opcode_t op);
    return op inside {add, sub, and_op, or_op, xor_op, addi, load, store};
  endfunction

  function automatic logic uses_rs2(input opcode_t op);
    return op inside {add, sub, and_op, or_op, xor_op, store};
  endfunction

  function automatic logic writes_rd(input opcode_t op);
    return op inside {add, sub, and_op, or_op, xor_op, addi, load};
  endfunction

endpackage

`default_nettype wire

/* logic/reg_read_if.sv */
`timescale 1ns/10ps
`default_nettype none

// operand read, data comes back in the same cycle
interface reg_read_if;

  logic                    rden1;
  logic                    rden2;
  pipeline_pkg::reg_addr_t raddr1;
  pipeline_pkg::reg_addr_t raddr2;
  pipeline_pkg::data_t     rdata1;
  pipeline_pkg::data_t     rdata2;

  modport requester (output rden1, rden2, raddr1, raddr2, input rdata1, rdata2);
  modport responder (input rden1, rden2, raddr1, raddr2, output rdata1, rdata2);

endinterface

`default_nettype wire

/* logic/result_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface result_if;

  logic                    wen0;
  pipeline_pkg::reg_addr_t waddr0;
  pipeline_pkg::data_t     wdata0;
  logic                    wen1;
  pipeline_pkg::reg_addr_t waddr1;
  pipeline_pkg::data_t     wdata1;
  // slot 0 value still on its way from memory
  logic                    load0;

  modport source (output wen0, waddr0, wdata0, wen1, waddr1, wdata1, load0);
  modport sink (input wen0, waddr0, wdata0, wen1, waddr1, wdata1, load0);

endinterface

`default_nettype wire

/* logic/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input wire            clock,
  input wire            reset,
  reg_read_if.responder rf0,
  reg_read_if.responder rf1,
  result_if.sink        wb
);

  pipeline_pkg::data_t regs [pipeline_pkg::reg_count];

  // write-through, slot 1 is the younger write
  function automatic pipeline_pkg::data_t read_port(
    input logic                    en,
    input pipeline_pkg::reg_addr_t addr
  );
    if (!en || addr == '0) return '0;
    if (wb.wen1 && wb.waddr1 == addr) return wb.wdata1;
    if (wb.wen0 && wb.waddr0 == addr) return wb.wdata0;
    return regs[addr];
  endfunction

  always_comb begin
    rf0.rdata1 = read_port(rf0.rden1, rf0.raddr1);
    rf0.rdata2 = read_port(rf0.rden2, rf0.raddr2);
    rf1.rdata1 = read_port(rf1.rden1, rf1.raddr1);
    rf1.rdata2 = read_port(rf1.rden2, rf1.raddr2);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < pipeline_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb.wen0) regs[wb.waddr0] <= wb.wdata0;
      if (wb.wen1) regs[wb.waddr1] <= wb.wdata1;
    end
  end

endmodule

`default_nettype wire

/* logic/forwarding_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module forwarding_unit (
  reg_read_if.responder req0,
  reg_read_if.responder req1,
  reg_read_if.requester rf0,
  reg_read_if.requester rf1,
  result_if.sink        exec_res,
  result_if.sink        mem_res
);

  // the execute result is newest and the register file oldest
  function automatic pipeline_pkg::data_t pick(
    input logic                    en,
    input pipeline_pkg::reg_addr_t addr,
    input pipeline_pkg::data_t     rf_data
  );
    if (!en || addr == '0) return rf_data;
    if (exec_res.wen1 && exec_res.waddr1 == addr) return exec_res.wdata1;
    if (exec_res.wen0 && !exec_res.load0 && exec_res.waddr0 == addr) begin
      return exec_res.wdata0;
    end
    if (mem_res.wen1 && mem_res.waddr1 == addr) return mem_res.wdata1;
    if (mem_res.wen0 && mem_res.waddr0 == addr) return mem_res.wdata0;
    return rf_data;
  endfunction

  always_comb begin
    rf0.rden1 = req0.rden1;
    rf0.rden2 = req0.rden2;
    rf0.raddr1 = req0.raddr1;
    rf0.raddr2 = req0.raddr2;
    rf1.rden1 = req1.rden1;
    rf1.rden2 = req1.rden2;
    rf1.raddr1 = req1.raddr1;
    rf1.raddr2 = req1.raddr2;

    req0.rdata1 = pick(req0.rden1, req0.raddr1, rf0.rdata1);
    req0.rdata2 = pick(req0.rden2, req0.raddr2, rf0.rdata2);
    req1.rdata1 = pick(req1.rden1, req1.raddr1, rf1.rdata1);
    req1.rdata2 = pick(req1.rden2, req1.raddr2, rf1.rdata2);
  end

endmodule

`default_nettype wire

/* logic/issue_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_stage (
  input wire                  clock,
  input wire                  reset,
  input wire                  in_valid,
  input wire pipeline_pkg::instr_t in_instr0,
  input wire pipeline_pkg::instr_t in_instr1,
  input wire                  flush,
  result_if.sink              exec_res,
  reg_read_if.requester       read0,
  reg_read_if.requester       read1,
  output logic                in_ready,
  output pipeline_pkg::slot_t slot0_q,
  output pipeline_pkg::slot_t slot1_q
);

  logic                load_dest;
  logic                stall;
  logic                accept;
  pipeline_pkg::slot_t slot0_d;
  pipeline_pkg::slot_t slot1_d;

  always_comb begin
    read0.rden1 = in_valid && pipeline_pkg::uses_rs1(in_instr0.op);
    read0.rden2 = in_valid && pipeline_pkg::uses_rs2(in_instr0.op);
    read0.raddr1 = in_instr0.rs1;
    read0.raddr2 = in_instr0.rs2;
    read1.rden1 = in_valid && pipeline_pkg::uses_rs1(in_instr1.op);
    read1.rden2 = in_valid && pipeline_pkg::uses_rs2(in_instr1.op);
    read1.raddr1 = in_instr1.rs1;
    read1.raddr2 = in_instr1.rs2;
  end

  // load in slot 0 of execute, its data only shows up one cycle later
  assign load_dest = exec_res.load0 && exec_res.wen0;

  assign stall = load_dest && (
    (read0.rden1 && read0.raddr1 == exec_res.waddr0) ||
    (read0.rden2 && read0.raddr2 == exec_res.waddr0) ||
    (read1.rden1 && read1.raddr1 == exec_res.waddr0) ||
    (read1.rden2 && read1.raddr2 == exec_res.waddr0));

  assign in_ready = !stall;
  assign accept = in_valid && !stall && !flush;

  always_comb begin
    slot0_d = pipeline_pkg::init_slot;
    slot1_d = pipeline_pkg::init_slot;
    if (accept) begin
      slot0_d.valid = 1'b1;
      slot0_d.instr = in_instr0;
      slot0_d.rdata1 = read0.rdata1;
      slot0_d.rdata2 = read0.rdata2;
      slot1_d.valid = 1'b1;
      slot1_d.instr = in_instr1;
      slot1_d.rdata1 = read1.rdata1;
      slot1_d.rdata2 = read1.rdata2;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      slot0_q <= pipeline_pkg::init_slot;
      slot1_q <= pipeline_pkg::init_slot;
    end else begin
      slot0_q <= slot0_d;
      slot1_q <= slot1_d;
    end
  end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input wire                 clock,
  input wire                 reset,
  input wire pipeline_pkg::slot_t slot0_in,
  input wire pipeline_pkg::slot_t slot1_in,
  output pipeline_pkg::slot_t slot0_q,
  output pipeline_pkg::slot_t slot1_q,
  result_if.source           exec_res
);

  pipeline_pkg::slot_t slot0_d;
  pipeline_pkg::slot_t slot1_d;

  function automatic pipeline_pkg::data_t alu(input pipeline_pkg::slot_t s);
    pipeline_pkg::data_t res;
    case (s.instr.op)
      pipeline_pkg::add:    res = s.rdata1 + s.rdata2;
      pipeline_pkg::sub:    res = s.rdata1 - s.rdata2;
      pipeline_pkg::and_op: res = s.rdata1 & s.rdata2;
      pipeline_pkg::or_op:  res = s.rdata1 | s.rdata2;
      pipeline_pkg::xor_op: res = s.rdata1 ^ s.rdata2;
      // addi and the memory address share the adder
      pipeline_pkg::addi,
      pipeline_pkg::load,
      pipeline_pkg::store:  res = s.rdata1 + s.instr.imm;
      default:              res = '0;
    endcase
    return res;
  endfunction

  always_comb begin
    slot0_d = slot0_in;
    slot0_d.rdata1 = alu(slot0_in);
    slot1_d = slot1_in;
    slot1_d.rdata1 = alu(slot1_in);

    exec_res.wen0 = slot0_in.valid && pipeline_pkg::writes_rd(slot0_in.instr.op) &&
                    slot0_in.instr.rd != '0;
    exec_res.waddr0 = slot0_in.instr.rd;
    exec_res.wdata0 = slot0_d.rdata1;
    exec_res.load0 = slot0_in.valid && slot0_in.instr.op == pipeline_pkg::load;
    exec_res.wen1 = slot1_in.valid && pipeline_pkg::writes_rd(slot1_in.instr.op) &&
                    slot1_in.instr.rd != '0;
    exec_res.waddr1 = slot1_in.instr.rd;
    exec_res.wdata1 = slot1_d.rdata1;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      slot0_q <= pipeline_pkg::init_slot;
      slot1_q <= pipeline_pkg::init_slot;
    end else begin
      slot0_q <= slot0_d;
      slot1_q <= slot1_d;
    end
  end

endmodule

`default_nettype wire

/* logic/memory_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_stage #(
  parameter int mem_depth = 64
) (
  input wire                      clock,
  input wire                      reset,
  input wire pipeline_pkg::slot_t slot0_in,
  input wire pipeline_pkg::slot_t slot1_in,
  result_if.source                mem_res,
  output logic                    wb0_valid,
  output pipeline_pkg::reg_addr_t wb0_rd,
  output pipeline_pkg::data_t     wb0_data,
  output logic                    wb1_valid,
  output pipeline_pkg::reg_addr_t wb1_rd,
  output pipeline_pkg::data_t     wb1_data
);

  localparam int index_bits = (mem_depth > 1) ? $clog2(mem_depth) : 1;

  pipeline_pkg::data_t   mem [mem_depth];
  logic [index_bits-1:0] mem_index;
  logic                  mem_write;

  // word index, wraps at mem_depth
  assign mem_index = index_bits'(slot0_in.rdata1 % mem_depth);
  assign mem_write = slot0_in.valid && slot0_in.instr.op == pipeline_pkg::store;

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < mem_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_write) begin
      mem[mem_index] <= slot0_in.rdata2;
    end
  end

  always_comb begin
    mem_res.wen0 = slot0_in.valid && pipeline_pkg::writes_rd(slot0_in.instr.op) &&
                   slot0_in.instr.rd != '0;
    mem_res.waddr0 = slot0_in.instr.rd;
    mem_res.wdata0 = (slot0_in.instr.op == pipeline_pkg::load) ? mem[mem_index] : slot0_in.rdata1;
    mem_res.load0 = 1'b0;
    mem_res.wen1 = slot1_in.valid && pipeline_pkg::writes_rd(slot1_in.instr.op) &&
                   slot1_in.instr.rd != '0;
    mem_res.waddr1 = slot1_in.instr.rd;
    mem_res.wdata1 = slot1_in.rdata1;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wb0_valid <= 1'b0;
      wb1_valid <= 1'b0;
    end else begin
      wb0_valid <= mem_res.wen0;
      wb1_valid <= mem_res.wen1;
    end
  end

  always_ff @(posedge clock) begin
    wb0_rd <= mem_res.waddr0;
    wb0_data <= mem_res.wdata0;
    wb1_rd <= mem_res.waddr1;
    wb1_data <= mem_res.wdata1;
  end

endmodule

`default_nettype wire

/* logic/pipeline_top.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeline_top #(
  parameter int mem_depth = 64
) (
  input wire                       clock,
  input wire                       reset,
  input wire                       in_valid,
  input wire pipeline_pkg::instr_t in_instr0,
  input wire pipeline_pkg::instr_t in_instr1,
  input wire                       flush,
  output logic                     in_ready,
  output logic                     wb0_valid,
  output pipeline_pkg::reg_addr_t  wb0_rd,
  output pipeline_pkg::data_t      wb0_data,
  output logic                     wb1_valid,
  output pipeline_pkg::reg_addr_t  wb1_rd,
  output pipeline_pkg::data_t      wb1_data
);

  pipeline_pkg::slot_t issue_slot0;
  pipeline_pkg::slot_t issue_slot1;
  pipeline_pkg::slot_t exec_slot0;
  pipeline_pkg::slot_t exec_slot1;

  reg_read_if issue_read0 ();
  reg_read_if issue_read1 ();
  reg_read_if rf_read0 ();
  reg_read_if rf_read1 ();
  result_if   exec_res ();
  result_if   mem_res ();

  issue_stage u_issue (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_instr0 (in_instr0),
    .in_instr1 (in_instr1),
    .flush     (flush),
    .exec_res  (exec_res.sink),
    .read0     (issue_read0.requester),
    .read1     (issue_read1.requester),
    .in_ready  (in_ready),
    .slot0_q   (issue_slot0),
    .slot1_q   (issue_slot1)
  );

  forwarding_unit u_forwarding (
    .req0     (issue_read0.responder),
    .req1     (issue_read1.responder),
    .rf0      (rf_read0.requester),
    .rf1      (rf_read1.requester),
    .exec_res (exec_res.sink),
    .mem_res  (mem_res.sink)
  );

  register_file u_regs (
    .clock (clock),
    .reset (reset),
    .rf0   (rf_read0.responder),
    .rf1   (rf_read1.responder),
    .wb    (mem_res.sink)
  );

  execute_stage u_execute (
    .clock    (clock),
    .reset    (reset),
    .slot0_in (issue_slot0),
    .slot1_in (issue_slot1),
    .slot0_q  (exec_slot0),
    .slot1_q  (exec_slot1),
    .exec_res (exec_res.source)
  );

  memory_stage #(
    .mem_depth (mem_depth)
  ) u_memory (
    .clock     (clock),
    .reset     (reset),
    .slot0_in  (exec_slot0),
    .slot1_in  (exec_slot1),
    .mem_res   (mem_res.source),
    .wb0_valid (wb0_valid),
    .wb0_rd    (wb0_rd),
    .wb0_data  (wb0_data),
    .wb1_valid (wb1_valid),
    .wb1_rd    (wb1_rd),
    .wb1_data  (wb1_data)
  );

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
  parameter int half_period = 5,
  parameter int reset_cycles = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  // active low, released just after an edge
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/pipeline_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeline_assertions (
  input wire clock,
  input wire reset,
  input wire flush,
  input wire in_ready,
  input wire wb0_valid,
  input wire wb1_valid
);

  int fail_count = 0;

  // a load-use stall lasts a single cycle
  stall_one_cycle: assert property (@(posedge clock) disable iff (!reset)
    !in_ready |=> in_ready)
    else begin
      fail_count++;
      $error("in_ready low for two cycles in a row");
    end

  wb_quiet_in_reset: assert property (@(posedge clock)
    !reset |=> (!wb0_valid && !wb1_valid))
    else begin
      fail_count++;
      $error("writeback valid high while in reset");
    end

  // the flushed pair would reach the wb ports three edges later
  flush_no_retire: assert property (@(posedge clock) disable iff (!reset)
    flush |-> ##3 (!wb0_valid && !wb1_valid))
    else begin
      fail_count++;
      $error("flushed pair retired");
    end

endmodule

`default_nettype wire

/* tb/pipeline_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeline_tb;

  localparam int mem_depth = 64;
  localparam int n_entries = 24;
  localparam int watchdog_ns = 20 * n_entries * 10;

  typedef struct packed {
    pipeline_pkg::reg_addr_t rd;
    pipeline_pkg::data_t     data;
    int                      cycle;
    int                      idx;
  } expect_t;

  logic                    clock;
  logic                    reset;
  logic                    in_valid;
  pipeline_pkg::instr_t    in_instr0;
  pipeline_pkg::instr_t    in_instr1;
  logic                    flush;
  logic                    in_ready;
  logic                    wb0_valid;
  pipeline_pkg::reg_addr_t wb0_rd;
  pipeline_pkg::data_t     wb0_data;
  logic                    wb1_valid;
  pipeline_pkg::reg_addr_t wb1_rd;
  pipeline_pkg::data_t     wb1_data;

  string                tab_name [n_entries];
  logic                 tab_flush [n_entries];
  int                   tab_stalls [n_entries];
  pipeline_pkg::instr_t tab_i0 [n_entries];
  pipeline_pkg::instr_t tab_i1 [n_entries];
  int                   tab_count = 0;

  pipeline_pkg::data_t ref_regs [pipeline_pkg::reg_count];
  pipeline_pkg::data_t ref_mem [mem_depth];
  expect_t             expected [$];
  pipeline_pkg::data_t imms [8];
  logic [15:0]         lfsr = 16'd83;
  int                  cycle_count = 0;
  int                  mismatch_count = 0;
  int                  other_count = 0;

  clock_gen #(.half_period(5), .reset_cycles(16)) u_clock (.clock(clock), .reset(reset));

  pipeline_top #(.mem_depth(mem_depth)) uut (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_instr0 (in_instr0),
    .in_instr1 (in_instr1),
    .flush     (flush),
    .in_ready  (in_ready),
    .wb0_valid (wb0_valid),
    .wb0_rd    (wb0_rd),
    .wb0_data  (wb0_data),
    .wb1_valid (wb1_valid),
    .wb1_rd    (wb1_rd),
    .wb1_data  (wb1_data)
  );

  bind pipeline_top pipeline_assertions u_checks (
    .clock     (clock),
    .reset     (reset),
    .flush     (flush),
    .in_ready  (in_ready),
    .wb0_valid (wb0_valid),
    .wb1_valid (wb1_valid)
  );

  // feedback polynomial x^16 + x^14 + x^13 + x^11
  function automatic pipeline_pkg::data_t rand_bits(input int n);
    pipeline_pkg::data_t v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic pipeline_pkg::instr_t make_instr(
    input pipeline_pkg::opcode_t op,
    input int                    rd,
    input int                    rs1,
    input int                    rs2,
    input pipeline_pkg::data_t   imm
  );
    pipeline_pkg::instr_t ins;
    ins.op = op;
    ins.rd = pipeline_pkg::reg_addr_t'(rd);
    ins.rs1 = pipeline_pkg::reg_addr_t'(rs1);
    ins.rs2 = pipeline_pkg::reg_addr_t'(rs2);
    ins.imm = imm;
    return ins;
  endfunction

  function automatic int mem_word(input pipeline_pkg::data_t addr);
    return int'(addr % pipeline_pkg::data_t'(mem_depth));
  endfunction

  task automatic add_entry(
    input string                name,
    input logic                 flush_bit,
    input int                   stalls,
    input pipeline_pkg::instr_t i0,
    input pipeline_pkg::instr_t i1
  );
    tab_name[tab_count] = name;
    tab_flush[tab_count] = flush_bit;
    tab_stalls[tab_count] = stalls;
    tab_i0[tab_count] = i0;
    tab_i1[tab_count] = i1;
    tab_count++;
  endtask

  task automatic fill_table();
    for (int i = 0; i < 8; i++) begin
      imms[i] = rand_bits(12);
    end
    add_entry("init_a", 1'b0, 0,
              make_instr(pipeline_pkg::addi, 1, 0, 0, imms[0]),
              make_instr(pipeline_pkg::addi, 2, 0, 0, imms[1]));
    add_entry("init_b", 1'b0, 0,
              make_instr(pipeline_pkg::addi, 3, 0, 0, imms[2]),
              make_instr(pipeline_pkg::addi, 4, 0, 0, imms[3]));
    add_entry("alu_pair", 1'b0, 0,
              make_instr(pipeline_pkg::add, 5, 1, 2, '0),
              make_instr(pipeline_pkg::sub, 6, 3, 4, '0));
    add_entry("logic_pair", 1'b0, 0,
              make_instr(pipeline_pkg::and_op, 7, 1, 3, '0),
              make_instr(pipeline_pkg::or_op, 8, 2, 4, '0));
    add_entry("xor_fwd", 1'b0, 0,
              make_instr(pipeline_pkg::xor_op, 9, 7, 8, '0),
              make_instr(pipeline_pkg::addi, 10, 5, 0, imms[4]));
    add_entry("zero_write", 1'b0, 0,
              make_instr(pipeline_pkg::addi, 0, 1, 0, imms[5]),
              make_instr(pipeline_pkg::or_op, 11, 6, 5, '0));
    add_entry("zero_read", 1'b0, 0,
              make_instr(pipeline_pkg::add, 12, 0, 9, '0),
              make_instr(pipeline_pkg::sub, 13, 10, 0, '0));
    add_entry("nop_pair", 1'b0, 0,
              make_instr(pipeline_pkg::nop, 3, 0, 0, '0),
              make_instr(pipeline_pkg::nop, 4, 0, 0, '0));
    add_entry("store_a", 1'b0, 0,
              make_instr(pipeline_pkg::store, 11, 1, 5, imms[6]),
              make_instr(pipeline_pkg::addi, 14, 2, 0, imms[7]));
    add_entry("load_a_wrap", 1'b0, 0,
              make_instr(pipeline_pkg::load, 15, 1, 0, imms[6] + 32'd64),
              make_instr(pipeline_pkg::xor_op, 3, 3, 4, '0));
    add_entry("load_use", 1'b0, 1,
              make_instr(pipeline_pkg::add, 6, 15, 2, '0),
              make_instr(pipeline_pkg::or_op, 7, 3, 0, '0));
    add_entry("load_b", 1'b0, 0,
              make_instr(pipeline_pkg::load, 8, 2, 0, imms[0]),
              make_instr(pipeline_pkg::addi, 9, 4, 0, imms[1]));
    add_entry("use_slot1", 1'b0, 1,
              make_instr(pipeline_pkg::add, 10, 9, 1, '0),
              make_instr(pipeline_pkg::xor_op, 11, 8, 5, '0));
    add_entry("store_b", 1'b0, 0,
              make_instr(pipeline_pkg::store, 9, 3, 11, imms[2]),
              make_instr(pipeline_pkg::sub, 12, 11, 10, '0));
    add_entry("load_b_wrap", 1'b0, 0,
              make_instr(pipeline_pkg::load, 13, 3, 0, imms[2] + 32'd128),
              make_instr(pipeline_pkg::and_op, 14, 12, 6, '0));
    add_entry("gap", 1'b0, 0,
              make_instr(pipeline_pkg::addi, 1, 1, 0, imms[3]),
              make_instr(pipeline_pkg::addi, 2, 2, 0, imms[4]));
    add_entry("load_mem_fwd", 1'b0, 0,
              make_instr(pipeline_pkg::add, 4, 13, 14, '0),
              make_instr(pipeline_pkg::or_op, 5, 1, 2, '0));
    add_entry("flush_a", 1'b1, 0,
              make_instr(pipeline_pkg::add, 6, 1, 1, '0),
              make_instr(pipeline_pkg::addi, 7, 2, 0, imms[5]));
    add_entry("after_flush", 1'b0, 0,
              make_instr(pipeline_pkg::add, 8, 6, 7, '0),
              make_instr(pipeline_pkg::sub, 9, 1, 2, '0));
    add_entry("flush_b", 1'b1, 0,
              make_instr(pipeline_pkg::xor_op, 10, 8, 9, '0),
              make_instr(pipeline_pkg::addi, 11, 0, 0, imms[6]));
    add_entry("store_c", 1'b0, 0,
              make_instr(pipeline_pkg::store, 15, 0, 8, imms[7]),
              make_instr(pipeline_pkg::addi, 10, 9, 0, imms[0]));
    add_entry("load_c", 1'b0, 0,
              make_instr(pipeline_pkg::load, 11, 0, 0, imms[7]),
              make_instr(pipeline_pkg::add, 12, 10, 8, '0));
    add_entry("load_chain", 1'b0, 1,
              make_instr(pipeline_pkg::load, 13, 11, 0, imms[1]),
              make_instr(pipeline_pkg::and_op, 14, 12, 10, '0));
    add_entry("consume", 1'b0, 1,
              make_instr(pipeline_pkg::add, 15, 13, 14, '0),
              make_instr(pipeline_pkg::or_op, 1, 0, 14, '0));
  endtask

  // architectural effect of one accepted pair with slot 0 applied first
  task automatic model_accept(input int idx);
    pipeline_pkg::instr_t ins [2];
    pipeline_pkg::data_t  a [2];
    pipeline_pkg::data_t  b [2];
    pipeline_pkg::data_t  res;
    logic                 wr;
    expect_t              e;
    ins[0] = tab_i0[idx];
    ins[1] = tab_i1[idx];
    for (int s = 0; s < 2; s++) begin
      a[s] = ref_regs[ins[s].rs1];
      b[s] = ref_regs[ins[s].rs2];
    end
    for (int s = 0; s < 2; s++) begin
      res = '0;
      wr = 1'b1;
      case (ins[s].op)
        pipeline_pkg::add:    res = a[s] + b[s];
        pipeline_pkg::sub:    res = a[s] - b[s];
        pipeline_pkg::and_op: res = a[s] & b[s];
        pipeline_pkg::or_op:  res = a[s] | b[s];
        pipeline_pkg::xor_op: res = a[s] ^ b[s];
        pipeline_pkg::addi:   res = a[s] + ins[s].imm;
        pipeline_pkg::load:   res = ref_mem[mem_word(a[s] + ins[s].imm)];
        pipeline_pkg::store: begin
          ref_mem[mem_word(a[s] + ins[s].imm)] = b[s];
          wr = 1'b0;
        end
        default: wr = 1'b0;
      endcase
      if (wr && ins[s].rd != '0) begin
        ref_regs[ins[s].rd] = res;
        e.rd = ins[s].rd;
        e.data = res;
        e.cycle = cycle_count + 3;
        e.idx = idx;
        expected.push_back(e);
      end
    end
  endtask

  task automatic check_data(
    input string               name,
    input pipeline_pkg::data_t exp,
    input pipeline_pkg::data_t act
  );
    if (act !== exp) begin
      $display("MISMATCH %s data expected %h actual %h", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic check_rd(
    input string                   name,
    input pipeline_pkg::reg_addr_t exp,
    input pipeline_pkg::reg_addr_t act
  );
    if (act !== exp) begin
      $display("MISMATCH %s rd expected %0d actual %0d", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic retire_slot(
    input int                      slot,
    input pipeline_pkg::reg_addr_t rd,
    input pipeline_pkg::data_t     data
  );
    expect_t e;
    if (expected.size() == 0) begin
      $display("ERROR: slot %0d retired r%0d = %h in cycle %0d but no result was expected",
               slot, rd, data, cycle_count);
      other_count++;
    end else begin
      e = expected.pop_front();
      check_rd(tab_name[e.idx], e.rd, rd);
      check_data(tab_name[e.idx], e.data, data);
      check_count({tab_name[e.idx], " retire cycle"}, e.cycle, cycle_count);
    end
  endtask

  always @(posedge clock) begin
    cycle_count++;
  end

  // wb ports change on the rising edge so they are sampled mid-cycle
  always @(negedge clock) begin
    if (reset) begin
      if (wb0_valid) retire_slot(0, wb0_rd, wb0_data);
      if (wb1_valid) retire_slot(1, wb1_rd, wb1_data);
    end
  end

  initial begin
    #(watchdog_ns);
    $display("ERROR: watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int stalls;
    in_valid = 1'b0;
    in_instr0 = '0;
    in_instr1 = '0;
    flush = 1'b0;
    for (int r = 0; r < pipeline_pkg::reg_count; r++) begin
      ref_regs[r] = '0;
    end
    for (int m = 0; m < mem_depth; m++) begin
      ref_mem[m] = '0;
    end
    fill_table();
    @(posedge reset);
    @(posedge clock);
    #1;
    for (int i = 0; i < n_entries; i++) begin
      in_valid = 1'b1;
      in_instr0 = tab_i0[i];
      in_instr1 = tab_i1[i];
      flush = tab_flush[i];
      stalls = 0;
      @(negedge clock);
      while (!in_ready) begin
        stalls++;
        @(negedge clock);
      end
      check_count({tab_name[i], " stall cycles"}, tab_stalls[i], stalls);
      // taken on the next rising edge unless flushed
      if (!tab_flush[i]) model_accept(i);
      @(posedge clock);
      #1;
    end
    in_valid = 1'b0;
    in_instr0 = '0;
    in_instr1 = '0;
    flush = 1'b0;
    repeat (6) @(negedge clock);
    if (expected.size() != 0) begin
      $display("ERROR: %0d expected results never retired", expected.size());
      other_count++;
    end
    $display("errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatch_count, other_count, uut.u_checks.fail_count);
    if (mismatch_count == 0 && other_count == 0 && uut.u_checks.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
logic/pipeline_pkg.sv
logic/reg_read_if.sv
logic/result_if.sv
logic/register_file.sv
logic/forwarding_unit.sv
logic/issue_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pipeline_top.sv
tb/clock_gen.sv
tb/pipeline_assertions.sv
tb/pipeline_tb.sv

/* Makefile */
SOURCES := $(wildcard logic/*.sv tb/*.sv)

.PHONY: run clean

run: obj_dir/Vpipeline_tb
	./obj_dir/Vpipeline_tb +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Simulation finished: FAIL" sim.log
	grep -q "Simulation finished: PASS" sim.log

obj_dir/Vpipeline_tb: compile.f $(SOURCES)
	verilator --binary --timing --assert --top-module pipeline_tb -f compile.f -o Vpipeline_tb

clean:
	rm -rf obj_dir sim.log
